/* Makefile */
# verilator flow for the instruction cache

TOP = icacheTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f filelist.f --top-module $(TOP) -o icacheSim
	./obj_dir/icacheSim 2>&1 | tee sim.log
	@if grep -q "Testbench failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
icachePkg.sv
icacheLineStore.sv
icacheFillCtrl.sv
icacheResult.sv
icacheTop.sv
icacheTb.sv

/* icacheFillCtrl.sv */
// miss handler that reads a line word by word over the bus and writes it into the store
`timescale 1ns/100ps
`default_nettype none

module icacheFillCtrl (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [icachePkg::XLEN-1:0]  pcF,
  input  logic                        hit,
  input  logic [icachePkg::XLEN-1:0]  instrInF,
  input  logic                        instrAckF,
  output logic                        instrReadF,
  output logic [icachePkg::XLEN-1:0]  instrPAdrF,
  output icachePkg::lineWrite_t       write,
  output logic                        fillBusy,
  output logic                        reread
);

  icachePkg::fillState_t state;
  icachePkg::fillState_t stateNext;

  // word counter with one slot per bus word in the line
  logic [$clog2(icachePkg::WORDS_PER_LINE)-1:0] wordCnt;
  logic                                         lastWord;

  // words collected from the bus with word 0 in the low bits
  logic [icachePkg::WORDS_PER_LINE-1:0][icachePkg::XLEN-1:0] fillBuf;

  // bus address pieces
  logic [icachePkg::XLEN-1:0] lineBase;
  logic [icachePkg::XLEN-1:0] wordOffset;

  //////////////////////////////
  // state machine
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= icachePkg::READY;
    end else begin
      state <= stateNext;
    end
  end

  assign lastWord = (wordCnt == $bits(wordCnt)'(icachePkg::WORDS_PER_LINE - 1));

  always_comb begin
    stateNext = state;
    case (state)
      icachePkg::READY: begin
        // any miss seen in ready starts a fill of the pc line
        if (!hit) begin
          stateNext = icachePkg::FETCH_WAIT;
        end
      end
      icachePkg::FETCH_WAIT: begin
        if (instrAckF && lastWord) begin
          stateNext = icachePkg::FETCH_DONE;
        end
      end
      icachePkg::FETCH_DONE: begin
        // line write takes this one cycle
        stateNext = icachePkg::REREAD;
      end
      icachePkg::REREAD: begin
        // store is read again here and the hit shows up back in ready
        stateNext = icachePkg::READY;
      end
      default: begin
        stateNext = icachePkg::READY;
      end
    endcase
  end

  //////////////////////////////
  // word counter and buffer
  //////////////////////////////

  // counter sits at zero in ready, so every fill starts at the line base
  always_ff @(posedge clk) begin
    if (rst || state == icachePkg::READY) begin
      wordCnt <= '0;
    end else if (instrReadF && instrAckF) begin
      wordCnt <= wordCnt + 1'b1;
    end
  end

  // one slot filled per acknowledged word
  always_ff @(posedge clk) begin
    if (instrReadF && instrAckF) begin
      fillBuf[wordCnt] <= instrInF;
    end
  end

  //////////////////////////////
  // bus side
  //////////////////////////////

  assign lineBase   = {pcF[icachePkg::XLEN-1:icachePkg::OFFSET_BITS],
                       {icachePkg::OFFSET_BITS{1'b0}}};
  // 4 bytes per word
  assign wordOffset = {{(icachePkg::XLEN - $bits(wordCnt) - 2){1'b0}}, wordCnt, 2'b00};

  // request and address stay put until the ack and then step to the next word
  assign instrReadF = (state == icachePkg::FETCH_WAIT);
  assign instrPAdrF = lineBase + wordOffset;

  //////////////////////////////
  // store side
  //////////////////////////////

  assign write.en    = (state == icachePkg::FETCH_DONE);
  assign write.index = pcF[icachePkg::OFFSET_BITS +: icachePkg::INDEX_BITS];
  assign write.tag   = pcF[icachePkg::XLEN-1 -: icachePkg::TAG_BITS];
  assign write.data  = fillBuf;

  assign fillBusy = (state != icachePkg::READY);
  assign reread   = (state == icachePkg::REREAD);

  // bus request and address hold until the word is acknowledged
  busHoldUntilAck: assert property (@(posedge clk) disable iff (rst)
    instrReadF && !instrAckF |=> instrReadF && $stable(instrPAdrF))
    else $error("bus request dropped or moved before its ack");

  // each acknowledged word moves the read one word up the line
  busStepAfterAck: assert property (@(posedge clk) disable iff (rst)
    instrReadF && instrAckF && !lastWord |=>
      instrReadF && instrPAdrF == $past(instrPAdrF) + 32'd4)
    else $error("bus read did not step to the next word");

endmodule

`default_nettype wire

/* icacheLineStore.sv */
// tag, valid and data arrays with a registered read, instantiated once by the cache top
`timescale 1ns/100ps
`default_nettype none

module icacheLineStore (
  input  logic                   clk,
  input  logic                   rst,
  input  icachePkg::lookupReq_t  lookup,
  input  icachePkg::lineWrite_t  write,
  output icachePkg::lookupResp_t resp
);

  // tag, data and valid storage
  logic [icachePkg::TAG_BITS-1:0]  tagArr  [icachePkg::NUM_LINES];
  logic [icachePkg::LINE_BITS-1:0] dataArr [icachePkg::NUM_LINES];
  logic [icachePkg::NUM_LINES-1:0] validBits;

  // request tag taken above index and byte offset
  logic [icachePkg::TAG_BITS-1:0]  reqTag;

  // read-side pipeline registers
  logic [icachePkg::TAG_BITS-1:0]  tagQ;
  logic [icachePkg::TAG_BITS-1:0]  reqTagQ;
  logic [icachePkg::LINE_BITS-1:0] dataQ;
  logic                            validQ;

  assign reqTag = lookup.pc[icachePkg::XLEN-1:icachePkg::OFFSET_BITS+icachePkg::INDEX_BITS];

  //////////////////////////////
  // write port
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (write.en) begin
      tagArr[write.index]  <= write.tag;
      dataArr[write.index] <= write.data;
    end
  end

  //////////////////////////////
  // registered read
  //////////////////////////////

  // a read in the write cycle sees the old line
  always_ff @(posedge clk) begin
    tagQ    <= tagArr[lookup.index];
    dataQ   <= dataArr[lookup.index];
    reqTagQ <= reqTag;
  end

  // valid bits set by line writes and cleared by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      validBits <= '0;
      validQ    <= 1'b0;
    end else begin
      if (write.en) begin
        validBits[write.index] <= 1'b1;
      end
      validQ <= validBits[lookup.index];
    end
  end

  // compare happens after the read register, so hit lags the request by one cycle
  assign resp.hit  = validQ && (tagQ == reqTagQ);
  assign resp.data = dataQ;

  // fill controller must always name a real line when it writes
  writeIndexKnown: assert property (@(posedge clk) disable iff (rst)
    write.en |-> !$isunknown(write.index))
    else $error("line write with unknown index");

endmodule

`default_nettype wire

/* icachePkg.sv */
// shared geometry, fill states and packed buses for the instruction cache, compiled first
`default_nettype none

package icachePkg;

  //////////////////////////////
  // geometry
  //////////////////////////////

  // data and address width
  localparam int XLEN = 32;
  // 16 lines of 4 words each
  localparam int LINE_BITS = 128;
  localparam int NUM_LINES = 16;
  localparam int WORDS_PER_LINE = 4;
  // pc splits as tag | index | byte offset
  localparam int OFFSET_BITS = 4;
  localparam int INDEX_BITS = 4;
  localparam int TAG_BITS = 24;

  // addi x0, x0, 0
  localparam logic [31:0] NOP = 32'h0000_0013;

  //////////////////////////////
  // fill controller states
  //////////////////////////////

  typedef enum logic [1:0] {
    READY,
    FETCH_WAIT,
    FETCH_DONE,
    REREAD
  } fillState_t;

  //////////////////////////////
  // packed buses between blocks
  //////////////////////////////

  // read request with the index pre-split and the full pc carried for the tag
  typedef struct packed {
    logic [INDEX_BITS-1:0] index;
    logic [XLEN-1:0]       pc;
  } lookupReq_t;

  // whole-line write from the fill controller
  typedef struct packed {
    logic                  en;
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic [LINE_BITS-1:0]  data;
  } lineWrite_t;

  // store output registered one cycle after the request
  typedef struct packed {
    logic                 hit;
    logic [LINE_BITS-1:0] data;
  } lookupResp_t;

endpackage

`default_nettype wire

/* icacheResult.sv */
// align stage that picks the fetched word and holds it in the decode register
`timescale 1ns/100ps
`default_nettype none

module icacheResult (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [icachePkg::LINE_BITS-1:0]  line,
  input  logic [icachePkg::XLEN-1:0]       pcF,
  input  logic                             advance,
  input  logic                             flushD,
  output logic                             compressedF,
  output logic [31:0]                      instrRawD
);

  // word within the line from pc bits 3:2
  logic [icachePkg::OFFSET_BITS-3:0] wordSel;
  logic [31:0]                       fetchWord;

  // decode register and the flush marker
  logic [31:0] instrQ;
  logic        flushHold;

  assign wordSel   = pcF[icachePkg::OFFSET_BITS-1:2];
  assign fetchWord = line[wordSel*icachePkg::XLEN +: icachePkg::XLEN];

  // rvc encodings never end in 2'b11
  assign compressedF = (fetchWord[1:0] != 2'b11);

  //////////////////////////////
  // decode register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      instrQ <= icachePkg::NOP;
    end else if (advance) begin
      instrQ <= fetchWord;
    end
  end

  // flush wins over an advance in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      flushHold <= 1'b0;
    end else if (flushD) begin
      flushHold <= 1'b1;
    end else if (advance) begin
      flushHold <= 1'b0;
    end
  end

  assign instrRawD = flushHold ? icachePkg::NOP : instrQ;

endmodule

`default_nettype wire

/* icacheTb.sv */
// self-checking testbench for the instruction cache, used as the simulation top
`timescale 1ns/100ps
`default_nettype none

module icacheTb;

  logic        clk;
  logic        rst;
  logic [31:0] pcNext;
  logic        stallD;
  logic        flushD;
  logic [31:0] instrRawD;
  logic        compressedF;
  logic        icacheStallF;
  logic        instrReadF;
  logic [31:0] instrPAdrF;
  logic [31:0] instrInF;
  logic        instrAckF;

  // separate generators for bus gaps and random pcs
  logic [31:0] busRng;
  logic [31:0] pcRng;

  // bus reads seen since the last delivered instruction
  logic [31:0] readLog[$];
  int          busReads;
  int          lineFills;
  int          checkCount;

  // which tag each line should hold
  logic [23:0] modelTag   [16];
  logic        modelValid [16];

  // fetched pc, decode register and flush marker as the checker sees them
  logic [31:0] fetchedPc;
  logic [31:0] modelQ;
  logic        modelFlush;
  logic        firstCycle;

  icacheTop UUT (
    .clk          (clk),
    .rst          (rst),
    .pcNext       (pcNext),
    .stallD       (stallD),
    .flushD       (flushD),
    .instrRawD    (instrRawD),
    .compressedF  (compressedF),
    .icacheStallF (icacheStallF),
    .instrReadF   (instrReadF),
    .instrPAdrF   (instrPAdrF),
    .instrInF     (instrInF),
    .instrAckF    (instrAckF)
  );

  //////////////////////////////
  // reference functions
  //////////////////////////////

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory image with every third word forced to a 32-bit encoding
  function automatic logic [31:0] memWord(input logic [31:0] addr);
    logic [31:0] w;
    w = addr ^ 32'h5a3c_96e1;
    if ((addr >> 2) % 32'd3 == 32'd0) begin
      w[1:0] = 2'b11;
    end
    return w;
  endfunction

  function automatic logic compressedRef(input logic [31:0] addr);
    if ((addr >> 2) % 32'd3 == 32'd0) begin
      return 1'b0;
    end
    // low bits follow the key
    return (addr[1:0] ^ 2'b01) != 2'b11;
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  //////////////////////////////
  // clock and bus responder
  //////////////////////////////

  initial begin : clockGen
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // 0 to 3 idle cycles before each acknowledged word
  initial begin : busResponder
    int   idleLeft;
    logic pending;
    instrAckF = 1'b0;
    instrInF  = '0;
    busRng    = 32'h32dd_ca5d;
    busReads  = 0;
    idleLeft  = 0;
    pending   = 1'b0;
    forever begin
      @(posedge clk);
      #5;
      instrAckF = 1'b0;
      if (!rst && instrReadF) begin
        if (!pending) begin
          busRng   = lcgNext(busRng);
          idleLeft = int'(busRng >> 30);
          pending  = 1'b1;
        end
        if (idleLeft == 0) begin
          instrAckF = 1'b1;
          instrInF  = memWord(instrPAdrF);
          readLog.push_back(instrPAdrF);
          busReads++;
          pending = 1'b0;
        end else begin
          idleLeft--;
        end
      end
    end
  end

  //////////////////////////////
  // checker
  //////////////////////////////

  // a miss must show exactly the four word reads of its line
  task automatic checkFill(input logic [31:0] pc);
    logic [31:0] base;
    logic [3:0]  idx;
    int          k;
    base = {pc[31:4], 4'h0};
    idx  = pc[7:4];
    if (modelValid[idx] && modelTag[idx] == pc[31:8]) begin
      assert (readLog.size() == 0)
        else failRun($sformatf("bus reads on a hit to line %h", base));
    end else begin
      assert (readLog.size() == 4)
        else failRun($sformatf("line %h filled with %0d bus reads instead of 4",
                               base, readLog.size()));
      for (k = 0; k < 4; k++) begin
        assert (readLog[k] == base + 32'(k * 4))
          else failRun($sformatf("MISMATCH instrPAdrF got %h expected %h",
                                 readLog[k], base + 32'(k * 4)));
      end
      modelValid[idx] = 1'b1;
      modelTag[idx]   = pc[31:8];
      lineFills++;
    end
    readLog.delete();
  endtask

  // sampled mid-cycle where DUT outputs and driven inputs are stable
  initial begin : resultCheck
    logic        adv;
    logic [31:0] expRaw;
    checkCount = 0;
    lineFills  = 0;
    forever begin
      @(negedge clk);
      if (rst) begin
        modelQ     = icachePkg::NOP;
        modelFlush = 1'b0;
        firstCycle = 1'b1;
        foreach (modelValid[i]) modelValid[i] = 1'b0;
        readLog.delete();
      end else begin
        expRaw = modelFlush ? icachePkg::NOP : modelQ;
        assert (instrRawD === expRaw)
          else failRun($sformatf("MISMATCH instrRawD got %h expected %h", instrRawD, expRaw));
        if (firstCycle) begin
          assert (instrReadF === 1'b0) else failRun("bus read active right after reset");
          assert (icacheStallF === 1'b1) else failRun("cache not stalled right after reset");
          // first edge out of reset takes the pc unconditionally
          fetchedPc  = pcNext;
          firstCycle = 1'b0;
        end else begin
          adv = !icacheStallF && !stallD;
          if (adv) begin
            assert (compressedF === compressedRef(fetchedPc))
              else failRun($sformatf("MISMATCH compressedF got %h expected %h",
                                     compressedF, compressedRef(fetchedPc)));
            checkFill(fetchedPc);
            modelQ    = memWord(fetchedPc);
            fetchedPc = pcNext;
            checkCount++;
          end
          if (flushD) begin
            modelFlush = 1'b1;
          end else if (adv) begin
            modelFlush = 1'b0;
          end
        end
      end
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // present a pc and return once the edge that takes it has passed
  task automatic feedPc(input logic [31:0] pc);
    int cycles;
    cycles = 0;
    pcNext = pc;
    while (icacheStallF) begin
      @(posedge clk);
      #5;
      cycles++;
      if (cycles > 200) begin
        failRun("timeout waiting for the cache to release its stall");
      end
    end
    @(posedge clk);
    #5;
  endtask

  task automatic holdStall(input int cycles);
    stallD = 1'b1;
    repeat (cycles) begin
      @(posedge clk);
      #5;
    end
    stallD = 1'b0;
  endtask

  // flush while stalled so NOP has to last until the next advance
  task automatic pulseFlush();
    stallD = 1'b1;
    flushD = 1'b1;
    @(posedge clk);
    #5;
    flushD = 1'b0;
    repeat (2) begin
      @(posedge clk);
      #5;
    end
    stallD = 1'b0;
  endtask

  initial begin : stimulus
    logic [31:0] pc;
    int          i;
    pcRng  = 32'h32dd_ca5d;
    rst    = 1'b1;
    pcNext = 32'h0000_1000;
    stallD = 1'b0;
    flushD = 1'b0;
    repeat (10) @(posedge clk);
    #5;
    rst = 1'b0;
    @(posedge clk);
    #5;
    // rest of line 0 and then line 1
    feedPc(32'h0000_1004);
    feedPc(32'h0000_1008);
    holdStall(3);
    feedPc(32'h0000_100c);
    feedPc(32'h0000_1010);
    feedPc(32'h0000_1014);
    pulseFlush();
    // same index with another tag and back again
    feedPc(32'h0000_2000);
    feedPc(32'h0000_2008);
    feedPc(32'h0000_1004);
    feedPc(32'h0000_101c);
    // two tags over all 16 lines
    for (i = 0; i < 24; i++) begin
      pcRng = lcgNext(pcRng);
      pc    = 32'h0000_4000 + ((pcRng >> 12) & 32'h0000_10fc);
      feedPc(pc);
      if (i % 5 == 2) holdStall(2);
      if (i % 7 == 3) pulseFlush();
    end
    // pushes the last pc through the decode register
    feedPc(32'h0000_1000);
    repeat (3) @(posedge clk);
    if (checkCount > 0) begin
      $display("%0d instructions checked, %0d line fills, %0d bus reads",
               checkCount, lineFills, busReads);
      $display("Testbench passed");
      $finish;
    end else begin
      failRun("no instruction reached the decode register");
    end
  end

endmodule

`default_nettype wire

/* icacheTop.sv */
// instruction cache top for the fetch stage, holds the fetched pc and joins store, fill and output
`timescale 1ns/100ps
`default_nettype none

module icacheTop (
  input  logic                        clk,
  input  logic                        rst,
  // fetch side
  input  logic [icachePkg::XLEN-1:0]  pcNext,
  input  logic                        stallD,
  input  logic                        flushD,
  output logic [31:0]                 instrRawD,
  output logic                        compressedF,
  output logic                        icacheStallF,
  // bus side
  output logic                        instrReadF,
  output logic [icachePkg::XLEN-1:0]  instrPAdrF,
  input  logic [icachePkg::XLEN-1:0]  instrInF,
  input  logic                        instrAckF
);

  icachePkg::lookupReq_t  lookupReq;
  icachePkg::lookupResp_t lookupResp;
  icachePkg::lineWrite_t  lineWrite;

  logic [icachePkg::XLEN-1:0] pcF;
  logic [icachePkg::XLEN-1:0] lookupPc;
  logic                       freshQ;
  logic                       capture;
  logic                       advance;
  logic                       lookupOk;
  logic                       fillBusy;
  logic                       reread;

  //////////////////////////////
  // fetched pc
  //////////////////////////////

  // high for the first cycle out of reset when no lookup is in flight yet
  always_ff @(posedge clk) begin
    if (rst) begin
      freshQ <= 1'b1;
    end else begin
      freshQ <= 1'b0;
    end
  end

  assign advance = lookupResp.hit && !fillBusy && !stallD;
  assign capture = advance || freshQ;

  always_ff @(posedge clk) begin
    if (capture) begin
      pcF <= pcNext;
    end
  end

  // new pc on capture and pcF again otherwise, which covers stalls and the reread
  assign lookupPc        = capture ? pcNext : pcF;
  assign lookupReq.index = lookupPc[icachePkg::OFFSET_BITS +: icachePkg::INDEX_BITS];
  assign lookupReq.pc    = lookupPc;

  // keeps the fill from starting on the empty response right after reset
  assign lookupOk     = lookupResp.hit || freshQ;
  assign icacheStallF = !lookupResp.hit || fillBusy;

  icacheLineStore store (
    .clk    (clk),
    .rst    (rst),
    .lookup (lookupReq),
    .write  (lineWrite),
    .resp   (lookupResp)
  );

  icacheFillCtrl fill (
    .clk        (clk),
    .rst        (rst),
    .pcF        (pcF),
    .hit        (lookupOk),
    .instrInF   (instrInF),
    .instrAckF  (instrAckF),
    .instrReadF (instrReadF),
    .instrPAdrF (instrPAdrF),
    .write      (lineWrite),
    .fillBusy   (fillBusy),
    .reread     (reread)
  );

  icacheResult result (
    .clk         (clk),
    .rst         (rst),
    .line        (lookupResp.data),
    .pcF         (pcF),
    .advance     (advance),
    .flushD      (flushD),
    .compressedF (compressedF),
    .instrRawD   (instrRawD)
  );

  // line written in FETCH_DONE must hit right after the reread
  refillHits: assert property (@(posedge clk) disable iff (rst)
    reread |=> lookupResp.hit)
    else $error("no hit after line refill");

endmodule

`default_nettype wire
